// ==== dv/sd_card_tb.sv ====
module sd_card_tb
   import sd_pkg::*;
();

   localparam int NUM_TESTS = 14;
   localparam int BOUND     = 64;   // clocks allowed for a start bit or busy

   logic sclk = 1'b0;
   logic rstn = 1'b0;
   logic ncs  = 1'b1;
   logic mosi = 1'b1;
   logic miso;

   int          n_checks = 0;
   int          n_errors = 0;
   logic [31:0] lcg_state = 32'd16;
   logic [7:0]  model_mem [0:NUM_BLOCKS*BLOCK_BYTES-1];

   // stimulus table
   string       t_name  [NUM_TESTS];
   logic [5:0]  t_index [NUM_TESTS];
   logic [31:0] t_arg   [NUM_TESTS];
   int          t_len   [NUM_TESTS];
   logic [7:0]  t_r1    [NUM_TESTS];
   logic [31:0] t_tail  [NUM_TESTS];

   sd_card sd_card_inst (
      .rstn (rstn),
      .sclk (sclk),
      .ncs  (ncs),
      .mosi (mosi),
      .miso (miso)
   );

   always #4 sclk = ~sclk;

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   task automatic set_row(input int i, input string name, input logic [5:0] idx,
                          input logic [31:0] arg, input int len, input logic [7:0] r1,
                          input logic [31:0] tail);
      t_name[i]  = name;
      t_index[i] = idx;
      t_arg[i]   = arg;
      t_len[i]   = len;
      t_r1[i]    = r1;
      t_tail[i]  = tail;
   endtask

   task automatic build_table();
      set_row(0,  "cmd0",          CMD_GO_IDLE,     32'h0,   1, 8'h01, 32'h0);
      set_row(1,  "unknown cmd",   6'd5,            32'h0,   1, 8'h05, 32'h0);
      set_row(2,  "acmd41 no app", ACMD_OP_COND,    32'h0,   1, 8'h05, 32'h0);
      set_row(3,  "cmd8 vhs 1",    CMD_IF_COND,     32'h1AA, 5, 8'h01, 32'h0000_01AA);
      set_row(4,  "cmd8 vhs 2",    CMD_IF_COND,     32'h2AA, 5, 8'h01, 32'h0000_00AA);
      set_row(5,  "cmd58 idle",    CMD_READ_OCR,    32'h0,   5, 8'h01,
              OCR_VALUE & 32'h7FFF_FFFF);                   // power-up bit still clear
      set_row(6,  "cmd17 idle",    CMD_READ_BLOCK,  32'h3,   1, 8'h01, 32'h0);
      set_row(7,  "cmd55",         CMD_APP,         32'h0,   1, 8'h01, 32'h0);
      set_row(8,  "acmd41",        ACMD_OP_COND,    32'h0,   1, 8'h00, 32'h0);
      set_row(9,  "cmd58 ready",   CMD_READ_OCR,    32'h0,   5, 8'h00, OCR_VALUE);
      set_row(10, "read blk 3",    CMD_READ_BLOCK,  32'h3,   1, 8'h00, 32'h0);
      set_row(11, "write blk 5",   CMD_WRITE_BLOCK, 32'h5,   1, 8'h00, 32'h0);
      set_row(12, "read blk 5",    CMD_READ_BLOCK,  32'h5,   1, 8'h00, 32'h0);
      set_row(13, "read blk 4",    CMD_READ_BLOCK,  32'h4,   1, 8'h00, 32'h0);
   endtask

   task automatic check(input string name, input logic [31:0] expected,
                        input logic [31:0] actual);
      n_checks++;
      if (expected !== actual) begin
         n_errors++;
         $display("FAILED %s: expected %h, actual %h", name, expected, actual);
      end
   endtask

   task automatic idle(input int n);
      repeat (n) begin
         @(posedge sclk);
         mosi <= 1'b1;
      end
   endtask

   task automatic send_bits(input logic [47:0] bits, input int n);
      for (int i = n - 1; i >= 0; i--) begin
         @(posedge sclk);
         mosi <= bits[i];
      end
   endtask

   task automatic send_cmd(input logic [5:0] idx, input logic [31:0] arg);
      send_bits({2'b01, idx, arg, 7'h00, 1'b1}, 48);   // crc is not checked
      idle(1);
   endtask

   // miso is read at the falling edge, halfway between updates
   task automatic wait_low(output bit found);
      found = 1'b0;
      for (int k = 0; k < BOUND && !found; k++) begin
         @(negedge sclk);
         found = !miso;
      end
   endtask

   task automatic shift_in(input int nbits, input bit have_first, output logic [39:0] val);
      logic b;
      val = '0;
      for (int k = 0; k < nbits; k++) begin
         if (k == 0 && have_first) begin
            b = 1'b0;   // the start bit is already sampled
         end else begin
            @(negedge sclk);
            b = miso;
         end
         val = {val[38:0], b};
      end
   endtask

   task automatic get_bytes(input string name, input int n, output bit found,
                            output logic [39:0] val);
      val = '0;
      wait_low(found);
      if (!found) begin
         n_errors++;
         $display("ERROR %s: no response start on miso within %0d clocks", name, BOUND);
      end else begin
         shift_in(n * 8, 1'b1, val);
      end
   endtask

   task automatic read_block(input string name, input logic [3:0] blk, input bit expect_data);
      bit          found;
      logic [39:0] val;
      if (!expect_data) begin
         wait_low(found);
         check($sformatf("%s no token", name), 32'd0, {31'd0, found});
      end else begin
         shift_in(16, 1'b0, val);   // one gap byte of ones, then the token
         check($sformatf("%s token", name), 32'hFFFE, {16'd0, val[15:0]});
         for (int k = 0; k < BLOCK_BYTES; k++) begin
            shift_in(8, 1'b0, val);
            check($sformatf("%s byte %0d", name, k), {24'd0, model_mem[{blk, 4'(k)}]},
                  val[31:0]);
         end
         shift_in(16, 1'b0, val);
         check($sformatf("%s crc", name), 32'hAAAA, val[31:0]);
      end
   endtask

   task automatic write_block(input string name, input logic [3:0] blk);
      logic [7:0]  b;
      logic [39:0] val;
      bit          found;
      bit          ended;
      int          busy;
      idle(16);   // receiver arms after the R1
      send_bits({40'd0, 8'hFE}, 8);
      for (int k = 0; k < BLOCK_BYTES; k++) begin
         lcg_state = lcg_next(lcg_state);
         b = lcg_state[23:16];
         model_mem[{blk, 4'(k)}] = b;
         send_bits({40'd0, b}, 8);
      end
      send_bits({32'd0, 16'h5A5A}, 16);
      idle(1);
      get_bytes($sformatf("%s dresp", name), 1, found, val);
      if (found) begin
         check($sformatf("%s dresp", name), 32'h05, val[31:0]);
         busy  = 0;
         ended = 1'b0;
         for (int k = 0; k < BOUND && !ended; k++) begin
            @(negedge sclk);
            if (miso)
               ended = 1'b1;
            else
               busy++;
         end
         check($sformatf("%s busy seen", name), 32'd1, {31'd0, busy >= 1});
         if (!ended) begin
            n_errors++;
            $display("ERROR %s: busy still low after %0d clocks", name, BOUND);
         end
      end
   endtask

   initial begin
      bit          found;
      logic [39:0] val;
      logic [7:0]  r1;
      logic [31:0] tail;
      build_table();
      for (int n = 0; n < NUM_BLOCKS * BLOCK_BYTES; n++)
         model_mem[n] = 8'(n + 3);   // power-on contents
      repeat (2) @(posedge sclk);
      rstn <= 1'b1;
      repeat (80) @(posedge sclk);
      ncs <= 1'b0;
      idle(8);
      for (int i = 0; i < NUM_TESTS; i++) begin
         send_cmd(t_index[i], t_arg[i]);
         get_bytes(t_name[i], t_len[i], found, val);
         if (found) begin
            r1   = (t_len[i] == 5) ? val[39:32] : val[7:0];
            tail = (t_len[i] == 5) ? val[31:0] : 32'd0;
            check($sformatf("%s r1", t_name[i]), {24'd0, t_r1[i]}, {24'd0, r1});
            if (t_len[i] == 5)
               check($sformatf("%s tail", t_name[i]), t_tail[i], tail);
            if (t_index[i] == CMD_READ_BLOCK)
               read_block(t_name[i], t_arg[i][3:0], t_r1[i] == 8'h00);
            if (t_index[i] == CMD_WRITE_BLOCK && t_r1[i] == 8'h00)
               write_block(t_name[i], t_arg[i][3:0]);
         end
         idle(8);
      end
      $display("%0d checks, %0d errors", n_checks, n_errors);
      if (n_errors == 0)
         $display("All checks passed");
      else
         $display("Checks failed");
      $finish;
   end

   // watchdog
   initial begin
      repeat (NUM_TESTS * 400) @(posedge sclk);
      $display("timeout: run did not finish within %0d cycles", NUM_TESTS * 400);
      $display("Checks failed");
      $finish;
   end

endmodule

// ==== filelist.f ====
hdl/sd_pkg.sv
hdl/sd_cmd_rx.sv
hdl/sd_cmd_exec.sv
hdl/sd_tx.sv
hdl/sd_data_rx.sv
hdl/sd_block_ram.sv
hdl/sd_card.sv
dv/sd_card_tb.sv

// ==== hdl/sd_block_ram.sv ====
module sd_block_ram
   import sd_pkg::*;
(
   input  logic              sclk,
   input  logic              we,
   input  logic [MEM_AW-1:0] waddr,
   input  logic [7:0]        wdata,
   input  logic [MEM_AW-1:0] raddr,
   output logic [7:0]        rdata
);

   logic [7:0] mem [0:NUM_BLOCKS*BLOCK_BYTES-1];

   // byte n holds n + offset, low byte only
   initial begin
      for (int n = 0; n < NUM_BLOCKS * BLOCK_BYTES; n++)
         mem[n] = 8'(n + MEM_INIT_OFFSET);
   end

   always_ff @(posedge sclk) begin
      if (we)
         mem[waddr] <= wdata;
      rdata <= mem[raddr];   // one cycle read
   end

endmodule

// ==== hdl/sd_card.sv ====
module sd_card
   import sd_pkg::*;
(
   input  logic rstn,
   input  logic sclk,
   input  logic ncs,
   input  logic mosi,
   output logic miso
);

   logic              hold;
   logic              cmd_valid;
   logic [5:0]        cmd_index;
   sd_arg_t           cmd_arg;
   logic              rsp_start;
   logic [2:0]        rsp_bytes;
   logic [39:0]       rsp_word;
   logic              rd_start;
   logic [BLK_AW-1:0] rd_block;
   logic              wr_start;
   logic [BLK_AW-1:0] wr_block;
   logic              tx_busy;
   logic              wr_busy;
   logic              dresp_start;
   logic              we;
   logic [MEM_AW-1:0] waddr;
   logic [7:0]        wdata;
   logic [MEM_AW-1:0] raddr;
   logic [7:0]        rdata;

   sd_cmd_rx sd_cmd_rx_inst (
      .rstn      (rstn),
      .sclk      (sclk),
      .ncs       (ncs),
      .mosi      (mosi),
      .hold      (hold),
      .cmd_valid (cmd_valid),
      .cmd_index (cmd_index),
      .cmd_arg   (cmd_arg)
   );

   sd_cmd_exec sd_cmd_exec_inst (
      .rstn      (rstn),
      .sclk      (sclk),
      .cmd_valid (cmd_valid),
      .cmd_index (cmd_index),
      .cmd_arg   (cmd_arg),
      .tx_busy   (tx_busy),
      .wr_busy   (wr_busy),
      .hold      (hold),
      .rsp_start (rsp_start),
      .rsp_bytes (rsp_bytes),
      .rsp_word  (rsp_word),
      .rd_start  (rd_start),
      .rd_block  (rd_block),
      .wr_start  (wr_start),
      .wr_block  (wr_block)
   );

   sd_tx sd_tx_inst (
      .rstn        (rstn),
      .sclk        (sclk),
      .rsp_start   (rsp_start),
      .rsp_bytes   (rsp_bytes),
      .rsp_word    (rsp_word),
      .rd_start    (rd_start),
      .rd_block    (rd_block),
      .dresp_start (dresp_start),
      .rdata       (rdata),
      .miso        (miso),
      .tx_busy     (tx_busy),
      .raddr       (raddr)
   );

   sd_data_rx sd_data_rx_inst (
      .rstn        (rstn),
      .sclk        (sclk),
      .mosi        (mosi),
      .wr_start    (wr_start),
      .wr_block    (wr_block),
      .wr_busy     (wr_busy),
      .dresp_start (dresp_start),
      .we          (we),
      .waddr       (waddr),
      .wdata       (wdata)
   );

   sd_block_ram sd_block_ram_inst (
      .sclk  (sclk),
      .we    (we),
      .waddr (waddr),
      .wdata (wdata),
      .raddr (raddr),
      .rdata (rdata)
   );

endmodule

// ==== hdl/sd_cmd_exec.sv ====
module sd_cmd_exec
   import sd_pkg::*;
(
   input  logic              rstn,
   input  logic              sclk,
   input  logic              cmd_valid,
   input  logic [5:0]        cmd_index,
   input  sd_arg_t           cmd_arg,
   input  logic              tx_busy,
   input  logic              wr_busy,
   output logic              hold,
   output logic              rsp_start,
   output logic [2:0]        rsp_bytes,
   output logic [39:0]       rsp_word,
   output logic              rd_start,
   output logic [BLK_AW-1:0] rd_block,
   output logic              wr_start,
   output logic [BLK_AW-1:0] wr_block
);

   logic              in_idle;
   logic              app_cmd;
   logic              wr_pend;    // write accepted, R1 still going out
   logic              tx_busy_q;
   logic              rsp_done;
   logic              illegal;
   logic              idle_nxt;
   logic              rd_ok;
   logic              wr_ok;
   logic [7:0]        r1;
   logic [3:0]        vhs_echo;
   logic [31:0]       ocr;
   logic [BLK_AW-1:0] blk_q;

   assign rsp_done = tx_busy_q & ~tx_busy;
   assign hold     = cmd_valid | rsp_start | tx_busy | wr_pend | wr_start | wr_busy;
   assign rd_block = blk_q;
   assign wr_block = blk_q;

   always_comb begin
      if (app_cmd)
         illegal = (cmd_index != ACMD_OP_COND);  // only ACMD41 is an app command here
      else
         illegal = !(cmd_index inside {CMD_GO_IDLE, CMD_IF_COND, CMD_READ_BLOCK,
                                       CMD_WRITE_BLOCK, CMD_APP, CMD_READ_OCR});
      idle_nxt = in_idle;
      if (!illegal && !app_cmd && cmd_index == CMD_GO_IDLE)
         idle_nxt = 1'b1;
      if (!illegal && app_cmd)
         idle_nxt = 1'b0;   // ACMD41 finishes init at once
      r1             = 8'h00;
      r1[R1_IDLE]    = idle_nxt;
      r1[R1_ILLEGAL] = illegal;
      vhs_echo = (cmd_arg.if_cond.vhs == CARD_VHS) ? cmd_arg.if_cond.vhs : 4'h0;
      ocr      = OCR_VALUE;
      ocr[31]  = OCR_VALUE[31] & ~in_idle;
      rd_ok    = !illegal && !in_idle && cmd_index == CMD_READ_BLOCK;
      wr_ok    = !illegal && !in_idle && cmd_index == CMD_WRITE_BLOCK;
   end

   always_ff @(posedge sclk) begin
      if (!rstn) begin
         in_idle   <= 1'b1;
         app_cmd   <= 1'b0;
         wr_pend   <= 1'b0;
         tx_busy_q <= 1'b0;
         rsp_start <= 1'b0;
         rd_start  <= 1'b0;
         wr_start  <= 1'b0;
      end else begin
         tx_busy_q <= tx_busy;
         rsp_start <= cmd_valid;
         rd_start  <= cmd_valid & rd_ok;
         wr_start  <= wr_pend & rsp_done;  // data phase opens after the R1
         if (cmd_valid) begin
            in_idle <= idle_nxt;
            app_cmd <= !illegal && cmd_index == CMD_APP;
            wr_pend <= wr_ok;
         end else if (rsp_done) begin
            wr_pend <= 1'b0;
         end
      end
   end

   always_ff @(posedge sclk) begin
      if (cmd_valid) begin
         blk_q <= cmd_arg.addr[BLK_AW-1:0];
         if (!illegal && cmd_index == CMD_IF_COND) begin
            rsp_bytes <= 3'd5;
            rsp_word  <= {r1, 20'h00000, vhs_echo, cmd_arg.if_cond.pattern};   // R7
         end else if (!illegal && cmd_index == CMD_READ_OCR) begin
            rsp_bytes <= 3'd5;
            rsp_word  <= {r1, ocr};   // R3
         end else begin
            rsp_bytes <= 3'd1;
            rsp_word  <= {r1, 32'h0000_0000};
         end
      end
   end

   // read launch and write launch are separated by the R1 of the write
   assert property (@(posedge sclk) disable iff (!rstn) !(rd_start && wr_start));

endmodule

// ==== hdl/sd_cmd_rx.sv ====
module sd_cmd_rx
   import sd_pkg::*;
(
   input  logic       rstn,
   input  logic       sclk,
   input  logic       ncs,
   input  logic       mosi,
   input  logic       hold,
   output logic       cmd_valid,
   output logic [5:0] cmd_index,
   output sd_arg_t    cmd_arg
);

   logic [6:0]            pu_cnt;
   logic                  pu_done;
   logic                  seen_zero;  // start bit seen, waiting for the 1
   logic                  in_frame;
   logic [5:0]            bit_cnt;
   logic [FRAME_BITS-1:0] frame;

   assign pu_done   = (pu_cnt == 7'(POWERUP_CLKS));
   assign cmd_index = frame[FRAME_BITS-1 -: 6];
   assign cmd_arg   = frame[FRAME_BITS-7 -: 32];  // crc7 and end bit sit below

   always_ff @(posedge sclk) begin
      if (!rstn) begin
         pu_cnt <= '0;
      end else if (!pu_done) begin
         pu_cnt <= pu_cnt + 7'd1;
      end
   end

   always_ff @(posedge sclk) begin
      if (!rstn) begin
         seen_zero <= 1'b0;
         in_frame  <= 1'b0;
         bit_cnt   <= '0;
         cmd_valid <= 1'b0;
      end else begin
         cmd_valid <= 1'b0;
         if (ncs) begin
            seen_zero <= 1'b0;
            in_frame  <= 1'b0;
         end else if (in_frame) begin
            bit_cnt <= bit_cnt + 6'd1;
            if (bit_cnt == 6'(FRAME_BITS - 1)) begin
               in_frame  <= 1'b0;
               cmd_valid <= 1'b1;   // end bit is in frame now
            end
         end else if (!pu_done || hold) begin
            seen_zero <= 1'b0;
         end else if (seen_zero && mosi) begin
            seen_zero <= 1'b0;
            in_frame  <= 1'b1;
            bit_cnt   <= '0;
         end else begin
            seen_zero <= !mosi;
         end
      end
   end

   always_ff @(posedge sclk) begin
      if (in_frame)
         frame <= {frame[FRAME_BITS-2:0], mosi};
   end

   // a frame must not complete while the previous command is still served
   assert property (@(posedge sclk) disable iff (!rstn) $rose(cmd_valid) |-> $past(!hold));

endmodule

// ==== hdl/sd_data_rx.sv ====
module sd_data_rx
   import sd_pkg::*;
(
   input  logic              rstn,
   input  logic              sclk,
   input  logic              mosi,
   input  logic              wr_start,
   input  logic [BLK_AW-1:0] wr_block,
   output logic              wr_busy,
   output logic              dresp_start,
   output logic              we,
   output logic [MEM_AW-1:0] waddr,
   output logic [7:0]        wdata
);

   logic [2:0]                 state;
   logic [MEM_AW-BLK_AW+2:0]   cnt;    // bit within block, then crc bit
   logic [7:0]                 sh;     // token history, then data byte
   logic [BLK_AW-1:0]          blk;

   assign wr_busy = (state != WR_IDLE);

   always_ff @(posedge sclk) begin
      if (!rstn) begin
         state       <= WR_IDLE;
         cnt         <= '0;
         we          <= 1'b0;
         dresp_start <= 1'b0;
      end else begin
         we          <= 1'b0;
         dresp_start <= 1'b0;
         case (state)
            WR_IDLE: begin
               cnt <= '0;
               if (wr_start)
                  state <= WR_HUNT;
            end
            WR_HUNT: begin
               // the token ends at the first 0 on mosi
               if (!mosi)
                  state <= ({sh[6:0], 1'b0} == TOKEN_START) ? WR_DATA : WR_IDLE;
            end
            WR_DATA: begin
               cnt <= cnt + 1'b1;
               if (cnt[2:0] == 3'd7)
                  we <= 1'b1;
               if (cnt == '1)
                  state <= WR_CRC;   // cnt wraps to 0 for the crc
            end
            WR_CRC: begin
               cnt <= cnt + 1'b1;
               if (cnt == 'd15) begin
                  dresp_start <= 1'b1;
                  state       <= WR_DONE;
               end
            end
            default: state <= WR_IDLE;   // busy covers the dresp_start cycle
         endcase
      end
   end

   always_ff @(posedge sclk) begin
      if (state == WR_IDLE) begin
         sh  <= 8'h00;   // too few ones before the 0 spoils the token
         blk <= wr_block;
      end else begin
         sh <= {sh[6:0], mosi};
      end
      if (state == WR_DATA && cnt[2:0] == 3'd7) begin
         wdata <= {sh[6:0], mosi};
         waddr <= {blk, cnt[MEM_AW-BLK_AW+2:3]};
      end
   end

   // a new block only opens once the previous one has drained
   assert property (@(posedge sclk) disable iff (!rstn) wr_start |-> !wr_busy);

endmodule

// ==== hdl/sd_pkg.sv ====
package sd_pkg;

   // command indices
   localparam logic [5:0] CMD_GO_IDLE     = 6'd0;
   localparam logic [5:0] CMD_IF_COND     = 6'd8;
   localparam logic [5:0] CMD_READ_BLOCK  = 6'd17;
   localparam logic [5:0] CMD_WRITE_BLOCK = 6'd24;
   localparam logic [5:0] CMD_APP         = 6'd55;
   localparam logic [5:0] ACMD_OP_COND    = 6'd41;
   localparam logic [5:0] CMD_READ_OCR    = 6'd58;

   localparam int BLOCK_BYTES     = 16;
   localparam int NUM_BLOCKS      = 16;
   localparam int MEM_AW          = 8;   // byte address
   localparam int BLK_AW          = 4;   // block number
   localparam int MEM_INIT_OFFSET = 3;
   localparam int POWERUP_CLKS    = 74;
   localparam int FRAME_BITS      = 46;  // index, argument, crc7, end bit

   // R1 bit positions
   localparam int R1_IDLE    = 0;
   localparam int R1_ILLEGAL = 2;

   localparam logic [3:0]  CARD_VHS      = 4'b0001;       // 2.7-3.6 V
   localparam logic [31:0] OCR_VALUE     = 32'hC0FF_8000; // done, high capacity, window
   localparam logic [7:0]  TOKEN_START   = 8'hFE;
   localparam logic [7:0]  DATA_RESP_OK  = 8'h05;
   localparam logic [15:0] READ_CRC_FILL = 16'hAAAA;

   // gaps in bytes of ones, busy in clocks
   localparam int NCR_BYTES = 1;
   localparam int NAC_BYTES = 1;
   localparam int BUSY_CLKS = 16;

   // miso phases
   localparam logic [3:0] PH_IDLE  = 4'd0;
   localparam logic [3:0] PH_GAP   = 4'd1;
   localparam logic [3:0] PH_RSP   = 4'd2;
   localparam logic [3:0] PH_NAC   = 4'd3;
   localparam logic [3:0] PH_TOKEN = 4'd4;
   localparam logic [3:0] PH_DATA  = 4'd5;
   localparam logic [3:0] PH_CRC   = 4'd6;
   localparam logic [3:0] PH_DRESP = 4'd7;
   localparam logic [3:0] PH_BUSY  = 4'd8;
   localparam logic [3:0] PH_END   = 4'd9;

   // write receiver states
   localparam logic [2:0] WR_IDLE = 3'd0;
   localparam logic [2:0] WR_HUNT = 3'd1;
   localparam logic [2:0] WR_DATA = 3'd2;
   localparam logic [2:0] WR_CRC  = 3'd3;
   localparam logic [2:0] WR_DONE = 3'd4;

   // command argument, block number or CMD8 fields
   typedef union packed {
      logic [31:0] addr;
      struct packed {
         logic [19:0] rsvd;
         logic [3:0]  vhs;
         logic [7:0]  pattern;
      } if_cond;
   } sd_arg_t;

endpackage

// ==== hdl/sd_tx.sv ====
module sd_tx
   import sd_pkg::*;
(
   input  logic              rstn,
   input  logic              sclk,
   input  logic              rsp_start,
   input  logic [2:0]        rsp_bytes,
   input  logic [39:0]       rsp_word,
   input  logic              rd_start,
   input  logic [BLK_AW-1:0] rd_block,
   input  logic              dresp_start,
   input  logic [7:0]        rdata,
   output logic              miso,
   output logic              tx_busy,
   output logic [MEM_AW-1:0] raddr
);

   logic [3:0]               phase;
   logic [3:0]               nxt_phase;
   logic [2:0]               bit_cnt;
   logic [4:0]               cnt;        // bytes in phase, or busy clocks
   logic [7:0]               sh;
   logic [7:0]               nxt_byte;
   logic [39:0]              rsp_q;
   logic [2:0]               rsp_len;
   logic                     rd_en;
   logic [BLK_AW-1:0]        rd_blk;
   logic [MEM_AW-BLK_AW-1:0] ptr;        // next byte to fetch
   logic                     last_byte;

   assign tx_busy = (phase != PH_IDLE);
   assign raddr   = {rd_blk, ptr};

   always_comb begin
      case (phase)
         PH_GAP:  last_byte = (cnt == 5'(NCR_BYTES - 1));
         PH_RSP:  last_byte = (cnt == 5'(rsp_len) - 5'd1);
         PH_NAC:  last_byte = (cnt == 5'(NAC_BYTES - 1));
         PH_DATA: last_byte = (ptr == '0);   // wrapped after the last fetch
         PH_CRC:  last_byte = (cnt == 5'd1);
         default: last_byte = 1'b1;
      endcase
   end

   always_comb begin
      nxt_phase = phase;
      nxt_byte  = 8'hFF;
      if (!last_byte) begin
         case (phase)
            PH_RSP:  nxt_byte = rsp_q[39:32];
            PH_DATA: nxt_byte = rdata;
            PH_CRC:  nxt_byte = READ_CRC_FILL[7:0];
            default: nxt_byte = 8'hFF;
         endcase
      end else begin
         case (phase)
            PH_GAP: begin
               nxt_phase = PH_RSP;
               nxt_byte  = rsp_q[39:32];
            end
            PH_RSP:   nxt_phase = rd_en ? PH_NAC : PH_END;
            PH_NAC: begin
               nxt_phase = PH_TOKEN;
               nxt_byte  = TOKEN_START;
            end
            PH_TOKEN: begin
               nxt_phase = PH_DATA;
               nxt_byte  = rdata;
            end
            PH_DATA: begin
               nxt_phase = PH_CRC;
               nxt_byte  = READ_CRC_FILL[15:8];
            end
            PH_DRESP: nxt_phase = PH_BUSY;
            default:  nxt_phase = PH_END;
         endcase
      end
   end

   always_ff @(posedge sclk) begin
      if (!rstn) begin
         phase   <= PH_IDLE;
         miso    <= 1'b1;
         bit_cnt <= '0;
         cnt     <= '0;
         rd_en   <= 1'b0;
         ptr     <= '0;
      end else begin
         case (phase)
            PH_IDLE: begin
               miso    <= 1'b1;
               bit_cnt <= '0;
               cnt     <= '0;
               ptr     <= '0;
               if (rsp_start) begin
                  phase <= PH_GAP;
                  rd_en <= rd_start;
               end else if (dresp_start) begin
                  phase <= PH_DRESP;
                  rd_en <= 1'b0;
               end
            end
            PH_BUSY: begin
               miso <= 1'b0;   // card programming
               cnt  <= cnt + 5'd1;
               if (cnt == 5'(BUSY_CLKS - 1))
                  phase <= PH_END;
            end
            PH_END: begin
               miso  <= 1'b1;
               phase <= PH_IDLE;
            end
            default: begin
               miso    <= sh[7];
               bit_cnt <= bit_cnt + 3'd1;
               if (bit_cnt == 3'd7) begin
                  phase <= nxt_phase;
                  cnt   <= (nxt_phase == phase) ? cnt + 5'd1 : 5'd0;
                  if (nxt_phase == PH_DATA)
                     ptr <= ptr + 1'b1;   // prefetch the following byte
               end
            end
         endcase
      end
   end

   always_ff @(posedge sclk) begin
      if (phase == PH_IDLE) begin
         if (rsp_start) begin
            sh      <= 8'hFF;
            rsp_q   <= rsp_word;
            rsp_len <= rsp_bytes;
            rd_blk  <= rd_block;
         end else if (dresp_start) begin
            sh <= DATA_RESP_OK;
         end
      end else if (phase != PH_BUSY && phase != PH_END) begin
         if (bit_cnt == 3'd7) begin
            sh <= nxt_byte;
            if (nxt_phase == PH_RSP)
               rsp_q <= {rsp_q[31:0], 8'h00};
         end else begin
            sh <= {sh[6:0], 1'b1};
         end
      end
   end

   // upstream stages wait for the previous transfer to drain
   assert property (@(posedge sclk) disable iff (!rstn)
                    (rsp_start || dresp_start) |-> !tx_busy);

endmodule
